// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module memAccessTb -f verilog.f -o memAccessSim &&
./obj_dir/memAccessSim | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: src/busPkg.sv
package busPkg;

    localparam int DATA_BITS = 64;
    // one enable per byte lane
    localparam int MASK_BITS = DATA_BITS / 8;
    localparam int ADDR_BITS = 64;
    localparam int REG_BITS  = 5;

    typedef logic [DATA_BITS-1:0] dataT;
    typedef logic [MASK_BITS-1:0] maskT;
    typedef logic [ADDR_BITS-1:0] addrT;
    typedef logic [REG_BITS-1:0]  regIdxT;

endpackage

// File: src/loadAlign.sv
`timescale 1ns/1ps

module loadAlign (
    loadDataIf.dst         wb,
    output logic           wbValid,
    output busPkg::regIdxT wbRd,
    output busPkg::dataT   wbData
);

    logic [lsuPkg::SHIFT_BITS-1:0] shamt;
    busPkg::dataT                  shifted;
    logic                          isSigned;

    assign shamt    = {wb.offset, {lsuPkg::BYTE_SHIFT{1'b0}}};
    assign shifted  = wb.raw >> shamt;
    assign isSigned = !wb.width[lsuPkg::UNSIGNED_BIT];

    // truncate, then fill the upper bits
    always_comb begin
        case (wb.width)
            lsuPkg::WIDTH_BYTE, lsuPkg::WIDTH_UBYTE: begin
                wbData = {{(busPkg::DATA_BITS - 8){isSigned & shifted[7]}}, shifted[7:0]};
            end
            lsuPkg::WIDTH_HALF, lsuPkg::WIDTH_UHALF: begin
                wbData = {{(busPkg::DATA_BITS - 16){isSigned & shifted[15]}}, shifted[15:0]};
            end
            lsuPkg::WIDTH_WORD, lsuPkg::WIDTH_UWORD: begin
                wbData = {{(busPkg::DATA_BITS - 32){isSigned & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                wbData = shifted;
            end
        endcase
    end

    assign wbValid = wb.valid;
    assign wbRd    = wb.rd;

    // code travels from the request through both registers
    always_comb begin
        if (wb.valid) begin
            assert (wb.width != lsuPkg::WIDTH_UDOUBLE)
            else $error("unsigned double load reached writeback");
        end
    end

endmodule

// File: src/loadCapture.sv
`timescale 1ns/1ps

module loadCapture (
    input  logic         clk,
    input  logic         arstN,
    input  logic         memStall,
    input  busPkg::dataT rdataMem,
    loadTagIf.dst        tag,
    loadDataIf.src       wb
);

    // stalled cycle goes into writeback as a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= tag.valid && !memStall;
        end
    end

    // payload only follows a completed memory cycle
    always_ff @(posedge clk) begin
        if (!memStall) begin
            wb.width  <= tag.width;
            wb.offset <= tag.offset;
            wb.rd     <= tag.rd;
            wb.raw    <= rdataMem;
        end
    end

    // a stalled load stays put until its single capture
    assert property (@(posedge clk) disable iff (!arstN)
        tag.valid && memStall
        |=> tag.valid && $stable(tag.rd) && $stable(tag.width) && $stable(tag.offset));

endmodule

// File: src/lsuPkg.sv
package lsuPkg;

    localparam int WIDTH_BITS   = 3;
    localparam int OFFSET_BITS  = 3;
    localparam int UNSIGNED_BIT = 2;

    // byte offset to bit shift
    localparam int BYTE_SHIFT = 3;
    localparam int SHIFT_BITS = OFFSET_BITS + BYTE_SHIFT;

    // funct3 style access code
    typedef logic [WIDTH_BITS-1:0] accessWidthT;

    localparam accessWidthT WIDTH_BYTE    = 3'd0;
    localparam accessWidthT WIDTH_HALF    = 3'd1;
    localparam accessWidthT WIDTH_WORD    = 3'd2;
    localparam accessWidthT WIDTH_DOUBLE  = 3'd3;
    localparam accessWidthT WIDTH_UBYTE   = 3'd4;
    localparam accessWidthT WIDTH_UHALF   = 3'd5;
    localparam accessWidthT WIDTH_UWORD   = 3'd6;
    // reserved as RV64 has no unsigned double
    localparam accessWidthT WIDTH_UDOUBLE = 3'd7;

    // byte lanes touched at offset zero
    localparam logic [(1 << OFFSET_BITS)-1:0] MASK_BYTE   = 8'h01;
    localparam logic [(1 << OFFSET_BITS)-1:0] MASK_HALF   = 8'h03;
    localparam logic [(1 << OFFSET_BITS)-1:0] MASK_WORD   = 8'h0f;
    localparam logic [(1 << OFFSET_BITS)-1:0] MASK_DOUBLE = 8'hff;

    // offset bits that must be zero for a natural alignment
    localparam logic [OFFSET_BITS-1:0] ALIGN_BYTE   = 3'b000;
    localparam logic [OFFSET_BITS-1:0] ALIGN_HALF   = 3'b001;
    localparam logic [OFFSET_BITS-1:0] ALIGN_WORD   = 3'b011;
    localparam logic [OFFSET_BITS-1:0] ALIGN_DOUBLE = 3'b111;

endpackage

// File: src/memAccessUnit.sv
`timescale 1ns/1ps

module memAccessUnit (
    input  logic                clk,
    input  logic                arstN,
    input  logic                reqValid,
    input  logic                reqWrite,
    input  lsuPkg::accessWidthT reqWidth,
    input  busPkg::addrT        reqAddr,
    input  busPkg::dataT        reqData,
    input  busPkg::regIdxT      reqRd,
    input  logic                memStall,
    input  busPkg::dataT        rdataMem,
    output busPkg::addrT        addrMem,
    output logic                weMem,
    output logic                reMem,
    output busPkg::maskT        wmaskMem,
    output busPkg::dataT        wdataMem,
    output logic                wbValid,
    output busPkg::regIdxT      wbRd,
    output busPkg::dataT        wbData
);

    loadTagIf  tagIf ();
    loadDataIf dataIf ();

    // memory stage
    storeIssue storeIssue (
        .clk      (clk),
        .arstN    (arstN),
        .reqValid (reqValid),
        .reqWrite (reqWrite),
        .reqWidth (reqWidth),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .reqRd    (reqRd),
        .memStall (memStall),
        .addrMem  (addrMem),
        .weMem    (weMem),
        .reMem    (reMem),
        .wmaskMem (wmaskMem),
        .wdataMem (wdataMem),
        .tag      (tagIf.src)
    );

    // MEM/WB register
    loadCapture loadCapture (
        .clk      (clk),
        .arstN    (arstN),
        .memStall (memStall),
        .rdataMem (rdataMem),
        .tag      (tagIf.dst),
        .wb       (dataIf.src)
    );

    loadAlign loadAlign (
        .wb      (dataIf.dst),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

endmodule

// File: src/stageIf.sv
`timescale 1ns/1ps

// load tag leaving the memory stage
interface loadTagIf;
    logic                             valid;
    lsuPkg::accessWidthT              width;
    logic [lsuPkg::OFFSET_BITS-1:0]   offset;
    busPkg::regIdxT                   rd;

    modport src (
        output valid, width, offset, rd
    );

    modport dst (
        input valid, width, offset, rd
    );
endinterface

// MEM/WB contents with the raw read data still unaligned
interface loadDataIf;
    logic                             valid;
    lsuPkg::accessWidthT              width;
    logic [lsuPkg::OFFSET_BITS-1:0]   offset;
    busPkg::regIdxT                   rd;
    busPkg::dataT                     raw;

    modport src (
        output valid, width, offset, rd, raw
    );

    modport dst (
        input valid, width, offset, rd, raw
    );
endinterface

// File: src/storeIssue.sv
`timescale 1ns/1ps

module storeIssue (
    input  logic                clk,
    input  logic                arstN,
    input  logic                reqValid,
    input  logic                reqWrite,
    input  lsuPkg::accessWidthT reqWidth,
    input  busPkg::addrT        reqAddr,
    input  busPkg::dataT        reqData,
    input  busPkg::regIdxT      reqRd,
    input  logic                memStall,
    output busPkg::addrT        addrMem,
    output logic                weMem,
    output logic                reMem,
    output busPkg::maskT        wmaskMem,
    output busPkg::dataT        wdataMem,
    loadTagIf.src               tag
);

    logic [lsuPkg::OFFSET_BITS-1:0] offset;
    logic [lsuPkg::SHIFT_BITS-1:0]  shamt;
    busPkg::maskT                   baseMask;
    logic [lsuPkg::OFFSET_BITS-1:0] alignMask;
    lsuPkg::accessWidthT            widthQ;
    busPkg::regIdxT                 rdQ;

    assign offset = reqAddr[lsuPkg::OFFSET_BITS-1:0];
    assign shamt  = {offset, {lsuPkg::BYTE_SHIFT{1'b0}}};

    // lane mask and alignment by access size
    always_comb begin
        case (reqWidth)
            lsuPkg::WIDTH_BYTE, lsuPkg::WIDTH_UBYTE: begin
                baseMask  = lsuPkg::MASK_BYTE;
                alignMask = lsuPkg::ALIGN_BYTE;
            end
            lsuPkg::WIDTH_HALF, lsuPkg::WIDTH_UHALF: begin
                baseMask  = lsuPkg::MASK_HALF;
                alignMask = lsuPkg::ALIGN_HALF;
            end
            lsuPkg::WIDTH_WORD, lsuPkg::WIDTH_UWORD: begin
                baseMask  = lsuPkg::MASK_WORD;
                alignMask = lsuPkg::ALIGN_WORD;
            end
            default: begin
                baseMask  = lsuPkg::MASK_DOUBLE;
                alignMask = lsuPkg::ALIGN_DOUBLE;
            end
        endcase
    end

    // memory stage control that a stall freezes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            weMem    <= 1'b0;
            reMem    <= 1'b0;
            wmaskMem <= '0;
        end else if (!memStall) begin
            weMem    <= reqValid && reqWrite;
            reMem    <= reqValid && !reqWrite;
            wmaskMem <= (reqValid && reqWrite) ? busPkg::maskT'(baseMask << offset) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!memStall) begin
            addrMem  <= reqAddr;
            wdataMem <= reqData << shamt;
            widthQ   <= reqWidth;
            rdQ      <= reqRd;
        end
    end

    assign tag.valid  = reMem;
    assign tag.width  = widthQ;
    assign tag.offset = addrMem[lsuPkg::OFFSET_BITS-1:0];
    assign tag.rd     = rdQ;

    // misaligned accesses are not supported
    assert property (@(posedge clk) disable iff (!arstN)
        reqValid && !memStall |-> (offset & alignMask) == '0);

endmodule

// File: verif/memAccessChecker.sv
`timescale 1ns/1ps

module memAccessChecker (
    input  logic                clk,
    input  logic                arstN,
    input  logic                reqValid,
    input  logic                reqWrite,
    input  lsuPkg::accessWidthT reqWidth,
    input  busPkg::addrT        reqAddr,
    input  busPkg::dataT        reqData,
    input  busPkg::regIdxT      reqRd,
    input  logic                memStall,
    input  busPkg::addrT        addrMem,
    input  logic                weMem,
    input  logic                reMem,
    input  busPkg::maskT        wmaskMem,
    input  busPkg::dataT        wdataMem,
    input  logic                wbValid,
    input  busPkg::regIdxT      wbRd,
    input  busPkg::dataT        wbData,
    output int                  errors,
    output int                  checks,
    output int                  pending
);

    localparam int MEM_WORDS = 256;

    busPkg::dataT   shadow [MEM_WORDS];
    busPkg::regIdxT rdQ [$];
    busPkg::dataT   dataQ [$];
    logic           expWe;
    logic           expRe;
    logic           expWbValid;
    busPkg::maskT   expMask;
    busPkg::addrT   expAddr;
    busPkg::dataT   expWdata;

    // expected lanes, store data and extended load value for one access
    function automatic void refAccess(
        input  lsuPkg::accessWidthT            width,
        input  logic [lsuPkg::OFFSET_BITS-1:0] offset,
        input  busPkg::dataT                   storeData,
        input  busPkg::dataT                   memWord,
        output busPkg::maskT                   mask,
        output busPkg::dataT                   lanes,
        output busPkg::dataT                   wdata,
        output busPkg::dataT                   loadValue
    );
        int           size;
        busPkg::dataT keep;
        busPkg::dataT shifted;
        size    = 1 << width[1:0];
        keep    = (size == 8) ? '1 : (64'd1 << (8 * size)) - 64'd1;
        mask    = busPkg::maskT'(((1 << size) - 1) << offset);
        lanes   = keep << (8 * offset);
        wdata   = storeData << (8 * offset);
        shifted = memWord >> (8 * offset);
        loadValue = shifted & keep;
        // top kept bit is the sign
        if (!width[lsuPkg::UNSIGNED_BIT] && (shifted & keep & ~(keep >> 1)) != '0) begin
            loadValue = loadValue | ~keep;
        end
    endfunction

    task automatic checkValue(input string name, input busPkg::dataT got,
                              input busPkg::dataT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic updateModel();
        logic [7:0]   idx;
        busPkg::maskT mask;
        busPkg::dataT lanes;
        busPkg::dataT wdata;
        busPkg::dataT loadValue;
        if (!arstN) begin
            expWe      = 1'b0;
            expRe      = 1'b0;
            expWbValid = 1'b0;
            expMask    = '0;
        end else begin
            // stalled memory cycle sends a bubble
            expWbValid = expRe && !memStall;
            if (!memStall) begin
                idx = reqAddr[10:3];
                refAccess(reqWidth, reqAddr[lsuPkg::OFFSET_BITS-1:0], reqData, shadow[idx],
                          mask, lanes, wdata, loadValue);
                expWe    = reqValid && reqWrite;
                expRe    = reqValid && !reqWrite;
                expMask  = expWe ? mask : '0;
                expAddr  = reqAddr;
                expWdata = wdata;
                if (expWe) begin
                    shadow[idx] = (shadow[idx] & ~lanes) | (wdata & lanes);
                end
                if (expRe) begin
                    rdQ.push_back(reqRd);
                    dataQ.push_back(loadValue);
                end
            end
        end
        pending = rdQ.size();
    endtask

    task automatic compareOutputs();
        busPkg::regIdxT expRd;
        busPkg::dataT   expData;
        checkValue("weMem", 64'(weMem), 64'(expWe));
        checkValue("reMem", 64'(reMem), 64'(expRe));
        checkValue("wmaskMem", 64'(wmaskMem), 64'(expMask));
        if (expWe) begin
            checkValue("wdataMem", wdataMem, expWdata);
        end
        if (expWe || expRe) begin
            checkValue("addrMem", addrMem, expAddr);
        end
        checkValue("wbValid", 64'(wbValid), 64'(expWbValid));
        if (wbValid) begin
            if (rdQ.size() == 0) begin
                errors++;
                $display("writeback to register %0d arrived with no load outstanding", wbRd);
            end else begin
                expRd   = rdQ.pop_front();
                expData = dataQ.pop_front();
                checkValue("wbRd", 64'(wbRd), 64'(expRd));
                checkValue("wbData", wbData, expData);
            end
        end
        pending = rdQ.size();
    endtask

    // outputs compared at the falling edge and the model stepped at the rising edge
    initial begin
        errors  = 0;
        checks  = 0;
        pending = 0;
        expWe      = 1'b0;
        expRe      = 1'b0;
        expWbValid = 1'b0;
        expMask    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = (64'(i) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a5a_0f0f_3c3c_6969;
        end
        forever begin
            @(negedge clk);
            compareOutputs();
            @(posedge clk);
            updateModel();
        end
    end

endmodule

// File: verif/memAccessTb.sv
`timescale 1ns/1ps

module memAccessTb;

    localparam int           MEM_WORDS  = 256;
    localparam int           WAIT_LIMIT = 64;
    localparam busPkg::addrT BASE       = 64'h0000_0000_8000_0100;

    logic                clk;
    logic                arstN;
    logic                reqValid;
    logic                reqWrite;
    lsuPkg::accessWidthT reqWidth;
    busPkg::addrT        reqAddr;
    busPkg::dataT        reqData;
    busPkg::regIdxT      reqRd;
    logic                memStall;
    busPkg::dataT        rdataMem;
    busPkg::addrT        addrMem;
    logic                weMem;
    logic                reMem;
    busPkg::maskT        wmaskMem;
    busPkg::dataT        wdataMem;
    logic                wbValid;
    busPkg::regIdxT      wbRd;
    busPkg::dataT        wbData;
    int                  errors;
    int                  checks;
    int                  pending;
    logic                stallOn;
    logic                timedOut;
    int                  testCount;
    int                  checksBefore;
    int                  errorsBefore;
    busPkg::dataT        mem [MEM_WORDS];

    memAccessUnit DUT (.*);

    memAccessChecker chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic busPkg::dataT laneBits(input busPkg::maskT mask);
        busPkg::dataT lanes;
        lanes = '0;
        for (int b = 0; b < busPkg::MASK_BITS; b++) begin
            if (((mask >> b) & 8'd1) != 8'd0) begin
                lanes = lanes | (64'hff << (8 * b));
            end
        end
        return lanes;
    endfunction

    function automatic busPkg::addrT alignedAddr(input int word, input int offset, input int size);
        return BASE + busPkg::addrT'(8 * word + (offset & ~(size - 1)));
    endfunction

    // memory model indexed by address bits 10:3
    assign rdataMem = mem[addrMem[10:3]];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (64'(i) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a5a_0f0f_3c3c_6969;
        end
        forever begin
            @(posedge clk);
            if (weMem && !memStall) begin
                mem[addrMem[10:3]] <= (mem[addrMem[10:3]] & ~laneBits(wmaskMem))
                                    | (wdataMem & laneBits(wmaskMem));
            end
        end
    end

    // holds the request until an unstalled edge takes it
    task automatic issue(input logic write, input lsuPkg::accessWidthT width,
                         input busPkg::addrT addr, input busPkg::dataT data,
                         input busPkg::regIdxT rd);
        logic accepted;
        int   n;
        accepted = 1'b0;
        n = 0;
        while (!accepted && n < WAIT_LIMIT && !timedOut) begin
            reqValid = 1'b1;
            if (stallOn && $urandom_range(2, 0) == 0) begin
                // junk offered under the stall must be dropped
                memStall = 1'b1;
                reqWrite = 1'($urandom_range(1, 0));
                reqWidth = lsuPkg::WIDTH_DOUBLE;
                reqAddr  = alignedAddr(int'($urandom_range(3, 0)), 0, 8);
                reqData  = {$urandom, $urandom};
                reqRd    = busPkg::regIdxT'($urandom_range(31, 0));
            end else begin
                memStall = 1'b0;
                reqWrite = write;
                reqWidth = width;
                reqAddr  = addr;
                reqData  = data;
                reqRd    = rd;
            end
            @(posedge clk);
            accepted = !memStall;
            #2;
            n++;
        end
        if (!accepted && !timedOut) begin
            $display("timeout: request to address 0x%0h was never accepted", addr);
            timedOut = 1'b1;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        reqValid = 1'b0;
        memStall = 1'b0;
        while ((pending != 0 || n < 3) && n < WAIT_LIMIT && !timedOut) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (pending != 0 && !timedOut) begin
            $display("timeout: %0d loads never wrote back", pending);
            timedOut = 1'b1;
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("test %0d %s: %0d checks, %0d errors", testCount, name,
                 checks - checksBefore, errors - errorsBefore);
        checksBefore = checks;
        errorsBefore = errors;
    endtask

    task automatic storeSweep();
        int size;
        for (int w = 0; w < 4; w++) begin
            size = 1 << w;
            for (int off = 0; off < 8; off += size) begin
                issue(1'b1, lsuPkg::accessWidthT'(w), alignedAddr(0, off, size),
                      {$urandom, $urandom}, '0);
            end
        end
    endtask

    // every width at every aligned offset of one known word
    task automatic loadSweep(input logic zeroExt);
        int size;
        issue(1'b1, lsuPkg::WIDTH_DOUBLE, alignedAddr(1, 0, 8), 64'h70f1_d3e2_c3b4_9a05, '0);
        for (int w = 0; w < (zeroExt ? 3 : 4); w++) begin
            size = 1 << w;
            for (int off = 0; off < 8; off += size) begin
                issue(1'b0, {zeroExt, 2'(w)}, alignedAddr(1, off, size), '0,
                      busPkg::regIdxT'(8 * w + off));
            end
        end
    endtask

    task automatic randomAccess();
        logic                write;
        lsuPkg::accessWidthT width;
        int                  size;
        write = 1'($urandom_range(1, 0));
        width = lsuPkg::accessWidthT'(write ? $urandom_range(3, 0) : $urandom_range(6, 0));
        size  = 1 << width[1:0];
        issue(write, width,
              alignedAddr(int'($urandom_range(3, 0)), int'($urandom_range(7, 0)), size),
              {$urandom, $urandom}, busPkg::regIdxT'($urandom_range(31, 0)));
    endtask

    initial begin
        void'($urandom(32'h6ca554e2));
        arstN        = 1'b0;
        reqValid     = 1'b0;
        reqWrite     = 1'b0;
        reqWidth     = lsuPkg::WIDTH_BYTE;
        reqAddr      = '0;
        reqData      = '0;
        reqRd        = '0;
        memStall     = 1'b0;
        stallOn      = 1'b0;
        timedOut     = 1'b0;
        testCount    = 0;
        checksBefore = 0;
        errorsBefore = 0;
        repeat (2) @(posedge clk);
        #2;
        arstN = 1'b1;
        drain();
        endTest("reset values");
        storeSweep();
        drain();
        endTest("store masks and data");
        loadSweep(1'b0);
        drain();
        endTest("signed loads");
        loadSweep(1'b1);
        repeat (40) randomAccess();
        drain();
        endTest("unsigned loads and random traffic");
        stallOn = 1'b1;
        repeat (60) randomAccess();
        drain();
        endTest("memory stalls");
        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (!timedOut && errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/lsuPkg.sv
src/busPkg.sv
src/stageIf.sv
src/storeIssue.sv
src/loadCapture.sv
src/loadAlign.sv
src/memAccessUnit.sv
verif/memAccessChecker.sv
verif/memAccessTb.sv
